//--- Bender.yml
package:
  name: rv32i_inorder_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv32i_types.sv
      - verilog/fetcher.sv
      - verilog/circular_q.sv
      - verilog/decoder.sv
      - verilog/regfile.sv
      - verilog/execute_unit.sv
      - verilog/lsu.sv
      - verilog/mem_arbiter.sv
      - verilog/cpu.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/mem_model.sv
      - bench/cpu_tb.sv

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

	localparam int mem_words      = 1024;
	localparam int prog_words_max = 64;
	localparam int delay_max      = 7;
	localparam int test_runs      = 6;
	localparam int unsigned rand_seed = 32'h6e47_6ebf;
	// every instruction costs at most one fetch and one data access.
	localparam int cycle_limit = test_runs *
		(prog_words_max * 2 * (delay_max + 5) + 8 + 50);

	logic        clk;
	logic        reset;
	logic [2:0]  resp_delay;
	logic        mem_resp;
	logic        mem_read;
	logic        mem_write;
	logic [3:0]  mem_byte_enable;
	logic [31:0] mem_rdata;
	logic [31:0] mem_address;
	logic [31:0] mem_wdata;
	int unsigned cycles;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic [31:0] regs [32];
	logic [31:0] shadow_mem [logic [31:0]];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int unsigned prog_len;

	// seen at the memory port.
	logic [31:0] got_addr [$];
	logic [31:0] got_data [$];
	logic [31:0] got_reads [$];

	cpu cpu_inst (
		.clk, .reset, .mem_resp, .mem_rdata, .mem_read, .mem_write,
		.mem_byte_enable, .mem_address, .mem_wdata
	);

	mem_model #(.words(mem_words), .seed(rand_seed)) mem_inst (
		.clk, .reset, .max_delay(resp_delay), .mem_read, .mem_write,
		.mem_byte_enable, .mem_address, .mem_wdata, .mem_rdata, .mem_resp
	);

	always #10 clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail at %0t: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			stop_with_failure($sformatf("timeout: no store arrived in time within %0d cycles",
				cycle_limit));
	end

	// record completed accesses.
	always @(posedge clk) begin
		if (!reset && mem_resp && (mem_read || mem_write)) begin
			check_value("mem_byte_enable", {28'd0, mem_byte_enable}, 32'h0000_000f);
			if (mem_write) begin
				got_addr.push_back(mem_address);
				got_data.push_back(mem_wdata);
			end else begin
				got_reads.push_back(mem_address);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// rv32i semantics and assembler
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] rv32_result(input string op, input logic [31:0] a,
			input logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0]; // shifts use the low five bits only.
		if (op == "add") return a + b;
		if (op == "sub") return a - b;
		if (op == "sll") return a << sh;
		if (op == "slt") return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		if (op == "sltu") return (a < b) ? 32'd1 : 32'd0;
		if (op == "xor") return a ^ b;
		if (op == "srl") return a >> sh;
		if (op == "sra") return 32'($signed(a) >>> sh);
		if (op == "or") return a | b;
		return a & b;
	endfunction

	function automatic logic [2:0] funct3_of(input string op);
		if (op == "add" || op == "sub") return 3'd0;
		if (op == "sll") return 3'd1;
		if (op == "slt") return 3'd2;
		if (op == "sltu") return 3'd3;
		if (op == "xor") return 3'd4;
		if (op == "srl" || op == "sra") return 3'd5;
		if (op == "or") return 3'd6;
		return 3'd7;
	endfunction

	task automatic put_word(input logic [31:0] word);
		if (prog_len >= prog_words_max)
			stop_with_failure("test program is longer than the space reserved for it");
		mem_inst.mem[(`RESET_PC >> 2) + prog_len] = word;
		prog_len++;
	endtask

	task automatic op_rr(input string op, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		logic [6:0] f7;
		f7 = (op == "sub" || op == "sra") ? 7'b0100000 : 7'b0000000;
		put_word({f7, rs2, rs1, funct3_of(op), rd, 7'b0110011});
		if (rd != 5'd0)
			regs[rd] = rv32_result(op, regs[rs1], regs[rs2]);
	endtask

	task automatic op_ri(input string op, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		put_word({imm, rs1, funct3_of(op), rd, 7'b0010011});
		if (rd != 5'd0)
			regs[rd] = rv32_result(op, regs[rs1], {{20{imm[11]}}, imm});
	endtask

	task automatic lui_to(input logic [4:0] rd, input logic [19:0] imm);
		put_word({imm, rd, 7'b0110111});
		if (rd != 5'd0)
			regs[rd] = {imm, 12'h000};
	endtask

	task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] off);
		logic [31:0] addr;
		addr = regs[rs1] + {{20{off[11]}}, off};
		put_word({off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011});
		shadow_mem[addr] = regs[rs2];
		exp_addr.push_back(addr);
		exp_data.push_back(regs[rs2]);
	endtask

	task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] off);
		logic [31:0] addr;
		addr = regs[rs1] + {{20{off[11]}}, off};
		put_word({off, rs1, 3'b010, rd, 7'b0000011});
		if (!shadow_mem.exists(addr))
			stop_with_failure("test program loads from an address it never stored to");
		if (rd != 5'd0)
			regs[rd] = shadow_mem[addr];
	endtask

	task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h0000_0800; // addi sign-extends the low part.
		lui_to(rd, upper[31:12]);
		op_ri("add", rd, rd, value[11:0]);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test flow
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic start_test(input logic [2:0] delay);
		@(posedge clk);
		reset      <= 1'b1;
		resp_delay <= delay;
		@(posedge clk);
		// words outside the program carry their index under an unused opcode.
		for (int i = 0; i < mem_words; i++)
			mem_inst.mem[i] = {i[24:0], 7'b0001011};
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		shadow_mem.delete();
		exp_addr.delete();
		exp_data.delete();
		got_addr.delete();
		got_data.delete();
		got_reads.delete();
		prog_len = 0;
	endtask

	task automatic run_and_check(input bit check_fetch);
		int unsigned n;
		n = exp_addr.size();
		repeat (7) begin
			@(negedge clk);
			check_value("mem_read in reset", {31'd0, mem_read}, 32'd0);
			check_value("mem_write in reset", {31'd0, mem_write}, 32'd0);
			@(posedge clk);
		end
		reset <= 1'b0;
		while (got_addr.size() < n)
			@(posedge clk);
		for (int k = 0; k < n; k++) begin
			check_value($sformatf("store %0d address", k), got_addr[k], exp_addr[k]);
			check_value($sformatf("store %0d data", k), got_data[k], exp_data[k]);
		end
		// without loads every read is a fetch.
		if (check_fetch) begin
			for (int k = 0; k < got_reads.size(); k++)
				check_value($sformatf("fetch %0d address", k), got_reads[k],
					`RESET_PC + 32'(4 * k));
		end
	endtask

	task automatic alu_test(input logic [2:0] delay);
		string       rr_ops [10] = '{"add", "sub", "sll", "slt", "sltu", "xor", "srl",
			"sra", "or", "and"};
		string       ri_ops [9]  = '{"add", "slt", "sltu", "xor", "or", "and", "sll",
			"srl", "sra"};
		logic [11:0] ri_imm [9]  = '{12'hffb, 12'h007, 12'hfff, 12'h5a5, 12'h0f0,
			12'h7ff, 12'h005, 12'h009, 12'h409};
		start_test(delay);
		set_reg(5'd1, 32'h8765_4321);
		set_reg(5'd2, 32'h0000_1235);
		set_reg(5'd3, 32'h0000_0800);
		for (int k = 0; k < 10; k++) begin
			op_rr(rr_ops[k], 5'd4, 5'd1, 5'd2);
			store_word(5'd4, 5'd3, 12'(4 * k));
		end
		for (int k = 0; k < 9; k++) begin
			op_ri(ri_ops[k], 5'd5, 5'd1, ri_imm[k]);
			store_word(5'd5, 5'd3, 12'(40 + 4 * k));
		end
		run_and_check(1'b1);
	endtask

	task automatic lui_x0_test();
		start_test(3'd0);
		set_reg(5'd3, 32'h0000_0900);
		lui_to(5'd5, 20'habcde);
		store_word(5'd5, 5'd3, 12'd0);
		lui_to(5'd6, 20'hfffff);
		store_word(5'd6, 5'd3, 12'd4);
		lui_to(5'd0, 20'h12345); // x0 stays zero.
		store_word(5'd0, 5'd3, 12'd8);
		op_ri("add", 5'd0, 5'd5, 12'h123);
		store_word(5'd0, 5'd3, 12'd12);
		op_rr("add", 5'd0, 5'd5, 5'd6);
		store_word(5'd0, 5'd3, 12'd16);
		run_and_check(1'b1);
	endtask

	task automatic load_store_test(input logic [2:0] delay);
		start_test(delay);
		set_reg(5'd3, 32'h0000_0a00);
		set_reg(5'd7, 32'h1357_9bdf);
		store_word(5'd7, 5'd3, 12'd0);
		load_word(5'd8, 5'd3, 12'd0);
		op_ri("add", 5'd8, 5'd8, 12'd1);
		store_word(5'd8, 5'd3, 12'd4);
		load_word(5'd9, 5'd3, 12'd4);
		op_rr("add", 5'd10, 5'd9, 5'd7); // load result used at once.
		store_word(5'd10, 5'd3, 12'hffc);
		run_and_check(1'b0);
	endtask

	task automatic unsupported_test();
		start_test(3'd0);
		set_reg(5'd1, 32'h0f0f_1234);
		set_reg(5'd2, 32'h0000_0777);
		set_reg(5'd3, 32'h0000_0b00);
		op_rr("add", 5'd4, 5'd1, 5'd2);
		put_word({20'h00001, 5'd4, 7'b0010111}); // auipc x4.
		store_word(5'd4, 5'd3, 12'd0);
		put_word({20'h00010, 5'd4, 7'b1101111}); // jal x4.
		op_rr("sub", 5'd5, 5'd1, 5'd2);
		put_word({7'd0, 5'd2, 5'd1, 3'b000, 5'b01000, 7'b1100011}); // beq.
		store_word(5'd5, 5'd3, 12'd4);
		put_word(32'h0ff0_000f); // fence.
		op_ri("xor", 5'd6, 5'd1, 12'h0ff);
		put_word(32'h0000_0073);
		put_word(32'hffff_ffff);
		store_word(5'd6, 5'd3, 12'd8);
		run_and_check(1'b1);
	endtask

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		resp_delay = 3'd0;
		cycles     = 0;
		prog_len   = 0;
		alu_test(3'd0);
		lui_x0_test();
		load_store_test(3'd0);
		unsupported_test();
		// same programs again with a random memory latency.
		alu_test(3'(delay_max));
		load_store_test(3'(delay_max));
		$display("TEST PASSED");
		$finish;
	end

endmodule : cpu_tb

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
	parameter int          words = 1024,
	parameter int unsigned seed  = 32'h0
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [2:0]  max_delay, // extra response cycles, picked per access.
	input  logic        mem_read,
	input  logic        mem_write,
	input  logic [3:0]  mem_byte_enable,
	input  logic [31:0] mem_address,
	input  logic [31:0] mem_wdata,
	output logic [31:0] mem_rdata,
	output logic        mem_resp
);

	logic [31:0] mem [words];
	logic [31:0] wmask;
	logic        waiting;
	int unsigned remaining;
	int unsigned idx;
	int unsigned seed_value;

	// byte lanes updated by a write.
	assign wmask = {{8{mem_byte_enable[3]}}, {8{mem_byte_enable[2]}},
		{8{mem_byte_enable[1]}}, {8{mem_byte_enable[0]}}};

	initial begin
		mem_resp   = 1'b0;
		mem_rdata  = '0;
		waiting    = 1'b0;
		remaining  = 0;
		seed_value = seed;
		void'($urandom(seed_value));
		forever begin
			@(posedge clk);
			idx = mem_address[$clog2(words)+1:2]; // word index, wraps at the array size.
			if (reset) begin
				mem_resp <= 1'b0;
				waiting  <= 1'b0;
			end else if (mem_resp) begin
				mem_resp <= 1'b0; // one-cycle pulse.
			end else if (waiting) begin
				if (remaining == 0) begin
					mem_resp  <= 1'b1;
					waiting   <= 1'b0;
					mem_rdata <= mem[idx];
					if (mem_write)
						mem[idx] <= (mem[idx] & ~wmask) | (mem_wdata & wmask);
				end else begin
					remaining <= remaining - 1;
				end
			end else if (mem_read || mem_write) begin
				waiting   <= 1'b1;
				remaining <= $urandom % (32'(max_delay) + 1);
			end
		end
	end

endmodule : mem_model

//--- compile.f
+incdir+include
verilog/rv32i_types.sv
verilog/fetcher.sv
verilog/circular_q.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/execute_unit.sv
verilog/lsu.sv
verilog/mem_arbiter.sv
verilog/cpu.sv
bench/mem_model.sv
bench/cpu_tb.sv

//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core dimensions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// data and address width.
`define CPU_WIDTH 32

// default instruction queue depth, 2 or more.
`define IQ_DEPTH 4

// address of the first instruction fetched out of reset.
`define RESET_PC 32'h0

`endif

//--- verilog/circular_q.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module circular_q
	import rv32i_types::*;
#(
	parameter int depth = `IQ_DEPTH
)
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         enq,
	input  logic                         deq,
	input  rv32i_word                    in,
	output logic                         empty,
	output logic                         full,
	output logic [$clog2(depth+1)-1:0]   count,
	output rv32i_word                    out
);

	localparam int aw = $clog2(depth);
	localparam int cw = $clog2(depth+1);

	rv32i_word     mem [depth];
	logic [aw-1:0] head;
	logic [aw-1:0] tail;
	logic          do_enq;
	logic          do_deq;

	// pointers wrap at depth, which need not be a power of two.
	function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] p);
		if (p == aw'(depth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign do_enq = enq & ~full;
	assign do_deq = deq & ~empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (do_enq)
				tail <= next_ptr(tail);
			if (do_deq)
				head <= next_ptr(head);
			if (do_enq && !do_deq)
				count <= count + 1'b1;
			else if (do_deq && !do_enq)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_enq)
			mem[tail] <= in;
	end

	assign empty = (count == '0);
	assign full  = (count == cw'(depth));
	assign out   = mem[head]; // valid while empty is low.

	no_enq_full: assert property (@(posedge clk) disable iff (reset) !(enq && full))
		else $error("enqueue while queue full");
	no_deq_empty: assert property (@(posedge clk) disable iff (reset) !(deq && empty))
		else $error("dequeue while queue empty");

endmodule : circular_q

//--- verilog/cpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu
	import rv32i_types::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    mem_resp,
	input  rv32i_word               mem_rdata,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic [`CPU_WIDTH/8-1:0] mem_byte_enable,
	output rv32i_word               mem_address,
	output rv32i_word               mem_wdata
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// front end
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic                           iq_enq, iq_deq, iq_empty, iq_full;
	logic [$clog2(`IQ_DEPTH+1)-1:0] iq_count;
	rv32i_word                      iq_in, iq_out;
	logic                           fetch_read, fetch_resp;
	rv32i_word                      fetch_addr, fetch_rdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode, registers, execute
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	rv32i_opcode opcode;
	alu_ops      aluop;
	logic [4:0]  rd, rs1, rs2;
	rv32i_word   imm, rs1_out, rs2_out, rd_data;
	logic        use_imm, load_regfile;

	logic        start, is_store, done;
	rv32i_word   ex_addr, ex_data, load_data;
	logic        lsu_read, lsu_write, lsu_resp;
	rv32i_word   lsu_addr, lsu_wdata, lsu_rdata;

	fetcher fetcher (
		.q_full(iq_full), .q_count(iq_count), .enq(iq_enq), .out(iq_in), .*
	);

	circular_q #(.depth(`IQ_DEPTH)) iq (
		.clk, .reset, .enq(iq_enq), .deq(iq_deq), .in(iq_in), .empty(iq_empty),
		.full(iq_full), .count(iq_count), .out(iq_out)
	);

	decoder decoder (.instruction(iq_out), .*);

	regfile registers (.load(load_regfile), .in(rd_data), .*);

	execute_unit execute_unit (
		.empty(iq_empty), .deq(iq_deq), .mem_addr(ex_addr), .mem_data(ex_data), .*
	);

	lsu lsu (.addr(ex_addr), .wdata(ex_data), .rdata(load_data), .*);

	mem_arbiter mem_arbiter (.*);

endmodule : cpu

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder
	import rv32i_types::*;
(
	input  rv32i_word   instruction,
	output rv32i_opcode opcode,
	output logic [4:0]  rd,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output rv32i_word   imm,
	output alu_ops      aluop,
	output logic        use_imm
);

	rv32i_word  i_imm;
	rv32i_word  s_imm;
	rv32i_word  u_imm;
	logic [2:0] funct3;

	assign funct3 = instruction[14:12];
	assign i_imm  = {{20{instruction[31]}}, instruction[31:20]};
	assign s_imm  = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
	assign u_imm  = {instruction[31:12], 12'h000};

	// bit 30 picks sub over add only for register ops; shifts use it either way.
	function automatic alu_ops f3_to_aluop(input logic [2:0] f3, input logic b30,
			input logic is_reg);
		case (f3)
			3'b000:  return (is_reg && b30) ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return b30 ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	always_comb begin
		opcode  = op_imm;
		rd      = instruction[11:7];
		rs1     = instruction[19:15];
		rs2     = instruction[24:20];
		imm     = i_imm;
		aluop   = alu_add;
		use_imm = 1'b1;
		case (instruction[6:0])
			op_lui: begin
				opcode = op_lui;
				imm    = u_imm;
				aluop  = alu_pass_b;
			end
			op_load:  opcode = op_load; // address is rs1 + i_imm.
			op_store: begin
				opcode = op_store;
				imm    = s_imm;
			end
			op_imm: aluop = f3_to_aluop(funct3, instruction[30], 1'b0);
			op_reg: begin
				opcode  = op_reg;
				aluop   = f3_to_aluop(funct3, instruction[30], 1'b1);
				use_imm = 1'b0;
			end
			default: begin
				// anything else becomes addi x0, x0, 0.
				rd  = 5'd0;
				rs1 = 5'd0;
				imm = '0;
			end
		endcase
	end

endmodule : decoder

//--- verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
	import rv32i_types::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        empty,
	output logic        deq,
	input  rv32i_opcode opcode,
	input  logic [4:0]  rd,
	input  rv32i_word   imm,
	input  alu_ops      aluop,
	input  logic        use_imm,
	input  rv32i_word   rs1_out,
	input  rv32i_word   rs2_out,
	output logic        load_regfile,
	output rv32i_word   rd_data,
	output logic        start,
	output logic        is_store,
	output rv32i_word   mem_addr,
	output rv32i_word   mem_data,
	input  logic        done,
	input  rv32i_word   load_data
);

	exec_state_t state, next_state;
	rv32i_word   alu_b;
	rv32i_word   alu_out;
	logic        is_mem;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// alu
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign alu_b = use_imm ? imm : rs2_out;

	always_comb begin
		case (aluop)
			alu_add:    alu_out = rs1_out + alu_b;
			alu_sub:    alu_out = rs1_out - alu_b;
			alu_sll:    alu_out = rs1_out << alu_b[4:0];
			alu_slt:    alu_out = {31'd0, $signed(rs1_out) < $signed(alu_b)};
			alu_sltu:   alu_out = {31'd0, rs1_out < alu_b};
			alu_xor:    alu_out = rs1_out ^ alu_b;
			alu_srl:    alu_out = rs1_out >> alu_b[4:0];
			alu_sra:    alu_out = $signed(rs1_out) >>> alu_b[4:0];
			alu_or:     alu_out = rs1_out | alu_b;
			alu_and:    alu_out = rs1_out & alu_b;
			default:    alu_out = alu_b; // alu_pass_b.
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// issue and retire
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign is_mem   = (opcode == op_load) || (opcode == op_store);
	assign is_store = (opcode == op_store);
	assign mem_addr = rs1_out + imm;
	assign mem_data = rs2_out;

	always_comb begin
		next_state   = state;
		deq          = 1'b0;
		start        = 1'b0;
		load_regfile = 1'b0;
		rd_data      = alu_out;
		case (state)
			ex_issue: begin
				if (!empty) begin
					if (is_mem) begin
						start      = 1'b1; // lsu latches the operands now.
						next_state = ex_wait_mem;
					end else begin
						deq          = 1'b1;
						load_regfile = (rd != 5'd0);
					end
				end
			end
			default: begin
				if (done) begin
					deq          = 1'b1;
					load_regfile = !is_store && (rd != 5'd0);
					rd_data      = load_data;
					next_state   = ex_issue;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= ex_issue;
		else
			state <= next_state;
	end

	// one memory op at a time: no new start before the lsu reports done.
	single_start: assert property (@(posedge clk) disable iff (reset)
		start |=> (!start throughout done[->1]))
		else $error("start issued while a memory op is pending");

endmodule : execute_unit

//--- verilog/fetcher.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetcher
	import rv32i_types::*;
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            q_full,
	input  logic [$clog2(`IQ_DEPTH+1)-1:0]  q_count,
	input  logic                            fetch_resp,
	input  rv32i_word                       fetch_rdata,
	output logic                            fetch_read,
	output rv32i_word                       fetch_addr,
	output logic                            enq,
	output rv32i_word                       out
);

	localparam int cw = $clog2(`IQ_DEPTH+1);

	rv32i_word pc;
	logic      in_flight; // a read is outstanding.
	logic [cw:0] committed;
	logic        room;

	// slots already taken plus the one a pending read will fill.
	assign committed = {1'b0, q_count} + {{cw{1'b0}}, in_flight};
	assign room      = committed < `IQ_DEPTH;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc        <= `RESET_PC;
			in_flight <= 1'b0;
		end else if (in_flight) begin
			if (fetch_resp) begin
				in_flight <= 1'b0;
				pc        <= pc + 32'd4; // word lands in the queue at this edge.
			end
		end else if (room) begin
			in_flight <= 1'b1;
		end
	end

	assign fetch_read = in_flight;
	assign fetch_addr = pc;
	assign enq        = in_flight & fetch_resp;
	assign out        = fetch_rdata;

	// a read is only started with a free slot, so the response always fits.
	enq_not_full: assert property (@(posedge clk) disable iff (reset) !(enq && q_full))
		else $error("fetcher pushed into a full queue");

endmodule : fetcher

//--- verilog/lsu.sv
`timescale 1ns/1ps

module lsu
	import rv32i_types::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  logic      is_store,
	input  rv32i_word addr,
	input  rv32i_word wdata,
	output logic      done,
	output rv32i_word rdata,
	output logic      lsu_read,
	output logic      lsu_write,
	output rv32i_word lsu_addr,
	output rv32i_word lsu_wdata,
	input  rv32i_word lsu_rdata,
	input  logic      lsu_resp
);

	lsu_state_t state;
	logic       store_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= lsu_idle;
			store_q <= 1'b0;
		end else if (state == lsu_idle) begin
			if (start) begin
				state   <= lsu_busy;
				store_q <= is_store;
			end
		end else if (lsu_resp) begin
			state <= lsu_idle; // request dropped after its response.
		end
	end

	// address and data are held for the whole access.
	always_ff @(posedge clk) begin
		if (state == lsu_idle && start) begin
			lsu_addr  <= addr;
			lsu_wdata <= wdata;
		end
	end

	assign lsu_read  = (state == lsu_busy) && !store_q;
	assign lsu_write = (state == lsu_busy) && store_q;
	assign done      = (state == lsu_busy) && lsu_resp;
	assign rdata     = lsu_rdata; // valid in the done cycle.

endmodule : lsu

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_arbiter
	import rv32i_types::*;
(
	input  logic                    clk,
	input  logic                    reset,
	// fetcher side.
	input  logic                    fetch_read,
	input  rv32i_word               fetch_addr,
	output rv32i_word               fetch_rdata,
	output logic                    fetch_resp,
	// lsu side.
	input  logic                    lsu_read,
	input  logic                    lsu_write,
	input  rv32i_word               lsu_addr,
	input  rv32i_word               lsu_wdata,
	output rv32i_word               lsu_rdata,
	output logic                    lsu_resp,
	// external memory port.
	input  logic                    mem_resp,
	input  rv32i_word               mem_rdata,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic [`CPU_WIDTH/8-1:0] mem_byte_enable,
	output rv32i_word               mem_address,
	output rv32i_word               mem_wdata
);

	arb_state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= arb_idle;
		end else begin
			case (state)
				arb_idle: begin
					if (lsu_read || lsu_write)
						state <= arb_lsu; // lsu wins ties.
					else if (fetch_read)
						state <= arb_fetch;
				end
				default: if (mem_resp) state <= arb_idle;
			endcase
		end
	end

	always_comb begin
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		mem_address = fetch_addr;
		mem_wdata   = lsu_wdata;
		case (state)
			arb_fetch: mem_read = fetch_read;
			arb_lsu: begin
				mem_read    = lsu_read;
				mem_write   = lsu_write;
				mem_address = lsu_addr;
			end
			default: ;
		endcase
	end

	assign mem_byte_enable = '1; // word accesses only.
	assign fetch_resp      = (state == arb_fetch) && mem_resp;
	assign lsu_resp        = (state == arb_lsu) && mem_resp;
	assign fetch_rdata     = mem_rdata;
	assign lsu_rdata       = mem_rdata;

	no_read_write: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write))
		else $error("read and write raised together");

	// a request stays up with a steady address until memory answers.
	hold_request: assert property (@(posedge clk) disable iff (reset)
		((mem_read || mem_write) && !mem_resp) |=>
			((mem_read || mem_write) && $stable(mem_address)))
		else $error("memory request dropped before mem_resp");

endmodule : mem_arbiter

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile
	import rv32i_types::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       load,
	input  logic [4:0] rd,
	input  rv32i_word  in,
	input  logic [4:0] rs1,
	input  logic [4:0] rs2,
	output rv32i_word  rs1_out,
	output rv32i_word  rs2_out
);

	rv32i_word data [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				data[i] <= '0;
		end else if (load && rd != 5'd0) begin
			data[rd] <= in; // x0 is never written, so it reads zero.
		end
	end

	assign rs1_out = data[rs1];
	assign rs2_out = data[rs2];

endmodule : regfile

//--- verilog/rv32i_types.sv
package rv32i_types;

	`include "cpu_settings.svh"

	// data and address word.
	typedef logic [`CPU_WIDTH-1:0] rv32i_word;

	// major opcodes handled by the core.
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111, // load upper immediate.
		op_load  = 7'b0000011, // lw only.
		op_store = 7'b0100011, // sw only.
		op_imm   = 7'b0010011, // register-immediate alu ops.
		op_reg   = 7'b0110011  // register-register alu ops.
	} rv32i_opcode;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b // lui, result is operand b.
	} alu_ops;

	typedef enum logic {ex_issue, ex_wait_mem} exec_state_t;

	typedef enum logic {lsu_idle, lsu_busy} lsu_state_t;

	// who owns the memory port.
	typedef enum logic [1:0] {arb_idle, arb_fetch, arb_lsu} arb_state_t;

endpackage : rv32i_types
